/* rtl/platform_pkg.sv */
package platform_pkg;

    ////////////////////////////////////////////////////////////
    // bus regions, from address bits 31..28
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        REGION_RAM    = 2'd0,   // nibble below 2
        REGION_RTC    = 2'd1,   // nibble 2
        REGION_PLIC   = 2'd2,   // nibble 3 to 7
        REGION_PERIPH = 2'd3    // nibble 8 and up
    } region_e;

    // transmitter FSM
    typedef enum logic [1:0] {
        UART_IDLE  = 2'd0,
        UART_START = 2'd1,
        UART_DATA  = 2'd2,
        UART_STOP  = 2'd3
    } uart_state_e;

    ////////////////////////////////////////////////////////////
    // register offsets
    ////////////////////////////////////////////////////////////

    // rtc, byte offset on addr[3:0]
    localparam logic [3:0] RTC_MTIME_LO    = 4'd0;
    localparam logic [3:0] RTC_MTIME_HI    = 4'd4;
    localparam logic [3:0] RTC_MTIMECMP_LO = 4'd8;
    localparam logic [3:0] RTC_MTIMECMP_HI = 4'd12;

    // plic, byte offset on addr[7:0]
    localparam logic [7:0] PLIC_PENDING = 8'd0;
    localparam logic [7:0] PLIC_ENABLE  = 8'd4;
    localparam logic [7:0] PLIC_CLAIM   = 8'd8;

    // peripherals, byte offset on addr[7:0]
    localparam logic [7:0] PERIPH_TX_DATA = 8'd0;
    localparam logic [7:0] PERIPH_STATUS  = 8'd4;

    // interrupt source numbers, 0 means none
    localparam int SRC_BUTTON  = 1;
    localparam int SRC_TX_DONE = 2;

endpackage

/* rtl/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder
    import platform_pkg::*;
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        en_i,
    input  logic [3:0]  addr_region_i,
    output logic        rtc_en_o,
    output logic        plic_en_o,
    output logic        periph_en_o,
    input  logic [31:0] rtc_rdata_i,
    input  logic [31:0] plic_rdata_i,
    input  logic [31:0] periph_rdata_i,
    output logic [31:0] data_o
);

    region_e region_d;
    region_e region_q;
    logic    sel_valid_q;   // an access happened last cycle

    ////////////////////////////////////////////////////////////
    // region decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        if (addr_region_i < 4'h2) begin
            region_d = REGION_RAM;
        end else if (addr_region_i < 4'h3) begin
            region_d = REGION_RTC;
        end else if (addr_region_i < 4'h8) begin
            region_d = REGION_PLIC;
        end else begin
            region_d = REGION_PERIPH;
        end
    end

    assign rtc_en_o    = en_i && (region_d == REGION_RTC);
    assign plic_en_o   = en_i && (region_d == REGION_PLIC);
    assign periph_en_o = en_i && (region_d == REGION_PERIPH);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sel_valid_q <= 1'b0;
            region_q    <= REGION_RAM;
        end else begin
            sel_valid_q <= en_i;
            region_q    <= region_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // read data, one cycle after the strobe
    ////////////////////////////////////////////////////////////

    always_comb begin
        data_o = 32'h0;     // ram region and idle cycles
        if (sel_valid_q) begin
            case (region_q)
                REGION_RTC:    data_o = rtc_rdata_i;
                REGION_PLIC:   data_o = plic_rdata_i;
                REGION_PERIPH: data_o = periph_rdata_i;
                default:       data_o = 32'h0;
            endcase
        end
    end

endmodule

/* rtl/machine_timer.sv */
`timescale 1ns/1ps

module machine_timer
    import platform_pkg::*;
#(
    parameter int RTC_DIV = 1
)
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        en_i,
    input  logic [3:0]  addr_i,
    input  logic [3:0]  we_i,
    input  logic [31:0] data_i,
    output logic [31:0] rdata_o,
    output logic        mti_o
);

    logic [31:0] div_cnt;
    logic        tick;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        wr;

    // replace only the enabled byte lanes
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_w,
        input logic [31:0] new_w,
        input logic [3:0]  be
    );
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign wr   = en_i && (we_i != 4'h0);
    assign tick = (div_cnt == 32'(RTC_DIV - 1));   // one mtime step

    ////////////////////////////////////////////////////////////
    // prescaler and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_cnt  <= 32'h0;
            mtime    <= 64'h0;
            mtimecmp <= '1;     // no interrupt out of reset
        end else begin
            div_cnt <= tick ? 32'h0 : div_cnt + 32'h1;

            // a write to an mtime word beats the increment
            if (wr && addr_i == RTC_MTIME_LO) begin
                mtime[31:0] <= merge_bytes(mtime[31:0], data_i, we_i);
            end else if (wr && addr_i == RTC_MTIME_HI) begin
                mtime[63:32] <= merge_bytes(mtime[63:32], data_i, we_i);
            end else if (tick) begin
                mtime <= mtime + 64'h1;
            end

            if (wr && addr_i == RTC_MTIMECMP_LO) begin
                mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], data_i, we_i);
            end
            if (wr && addr_i == RTC_MTIMECMP_HI) begin
                mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], data_i, we_i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            mti_o <= 1'b0;
        end else begin
            mti_o <= (mtime >= mtimecmp);
        end
    end

    // read word, old value on a write cycle
    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i)
                RTC_MTIME_LO:    rdata_o <= mtime[31:0];
                RTC_MTIME_HI:    rdata_o <= mtime[63:32];
                RTC_MTIMECMP_LO: rdata_o <= mtimecmp[31:0];
                RTC_MTIMECMP_HI: rdata_o <= mtimecmp[63:32];
                default:         rdata_o <= 32'h0;
            endcase
        end
    end

endmodule

/* rtl/irq_controller.sv */
`timescale 1ns/1ps

module irq_controller
    import platform_pkg::*;
#(
    parameter int IRQ_CNT = 2
)
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic               en_i,
    input  logic [7:0]         addr_i,
    input  logic [3:0]         we_i,
    input  logic [31:0]        data_i,
    output logic [31:0]        rdata_o,
    input  logic [IRQ_CNT:1]   irq_i,
    output logic               mei_o
);

    logic [IRQ_CNT:1] irq_prev;
    logic [IRQ_CNT:1] irq_rise;
    logic [IRQ_CNT:1] pending;
    logic [IRQ_CNT:1] enable;
    logic [IRQ_CNT:1] in_service;
    logic [IRQ_CNT:1] claimable;
    logic [31:0]      claim_id;     // lowest claimable source, 0 if none
    logic             claim_rd;
    logic             complete_wr;
    logic             enable_wr;

    assign irq_rise  = irq_i & ~irq_prev;
    assign claimable = pending & enable & ~in_service;

    assign claim_rd    = en_i && (addr_i == PLIC_CLAIM) && (we_i == 4'h0);
    assign complete_wr = en_i && (addr_i == PLIC_CLAIM) && we_i[0];
    assign enable_wr   = en_i && (addr_i == PLIC_ENABLE) && we_i[0];

    // priority search, lowest number wins
    always_comb begin
        claim_id = 32'h0;
        for (int i = IRQ_CNT; i >= 1; i--) begin
            if (claimable[i]) begin
                claim_id = 32'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // gateways, pending and in-service bits
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            irq_prev   <= '0;
            pending    <= '0;
            enable     <= '0;
            in_service <= '0;
            mei_o      <= 1'b0;
        end else begin
            irq_prev <= irq_i;
            mei_o    <= |claimable;

            if (enable_wr) begin
                enable <= data_i[IRQ_CNT:1];
            end

            for (int i = 1; i <= IRQ_CNT; i++) begin
                // a new edge is kept even if claimed this cycle
                if (irq_rise[i]) begin
                    pending[i] <= 1'b1;
                end else if (claim_rd && claim_id == 32'(i)) begin
                    pending[i] <= 1'b0;
                end

                if (claim_rd && claim_id == 32'(i)) begin
                    in_service[i] <= 1'b1;
                end else if (complete_wr && data_i == 32'(i)) begin
                    in_service[i] <= 1'b0;
                end
            end
        end
    end

    // bit n of each word is source n
    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i)
                PLIC_PENDING: rdata_o <= 32'({pending, 1'b0});
                PLIC_ENABLE:  rdata_o <= 32'({enable, 1'b0});
                PLIC_CLAIM:   rdata_o <= claim_id;
                default:      rdata_o <= 32'h0;
            endcase
        end
    end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx
    import platform_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
)
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       start_i,
    input  logic [7:0] data_i,
    output logic       tx_o,
    output logic       busy_o,
    output logic       done_o
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    uart_state_e      state;
    logic [CNT_W-1:0] clk_cnt;      // clocks within current bit
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;      // lsb goes out first
    logic             bit_end;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign busy_o  = (state != UART_IDLE);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= UART_IDLE;
            clk_cnt <= '0;
            bit_idx <= 3'd0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (state == UART_IDLE) begin
                clk_cnt <= '0;
            end else begin
                clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            end

            case (state)
                UART_IDLE: begin
                    if (start_i) begin
                        state <= UART_START;
                    end
                end
                UART_START: begin
                    if (bit_end) begin
                        state   <= UART_DATA;
                        bit_idx <= 3'd0;
                    end
                end
                UART_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7) begin
                            state <= UART_STOP;
                        end
                    end
                end
                UART_STOP: begin
                    if (bit_end) begin
                        state  <= UART_IDLE;
                        done_o <= 1'b1;     // frame finished
                    end
                end
                default: state <= UART_IDLE;
            endcase
        end
    end

    // byte latch and shifter
    always_ff @(posedge clk) begin
        if (state == UART_IDLE && start_i) begin
            shift_q <= data_i;
        end else if (state == UART_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_comb begin
        case (state)
            UART_START: tx_o = 1'b0;
            UART_DATA:  tx_o = shift_q[0];
            default:    tx_o = 1'b1;    // idle and stop are mark
        endcase
    end

endmodule

/* rtl/peripherals.sv */
`timescale 1ns/1ps

module peripherals
    import platform_pkg::*;
#(
    parameter int IRQ_CNT      = 2,
    parameter int CLKS_PER_BIT = 868
)
(
    input  logic               clk,
    input  logic               rst_i,
    input  logic               en_i,
    input  logic [7:0]         addr_i,
    input  logic [3:0]         we_i,
    input  logic [31:0]        data_i,
    output logic [31:0]        rdata_o,
    input  logic               btn_i,
    output logic               uart_tx_o,
    output logic [IRQ_CNT:1]   irq_o
);

    logic        tx_start;
    logic        tx_busy;
    logic        tx_done;
    logic        btn_meta;
    logic        btn_sync;
    logic        btn_prev;
    logic        btn_rise;
    logic [31:0] status;

    ////////////////////////////////////////////////////////////
    // uart transmitter
    ////////////////////////////////////////////////////////////

    // dropped inside uart_tx when busy
    assign tx_start = en_i && (addr_i == PERIPH_TX_DATA) && we_i[0];

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk     (clk),
        .rst_i   (rst_i),
        .start_i (tx_start),
        .data_i  (data_i[7:0]),
        .tx_o    (uart_tx_o),
        .busy_o  (tx_busy),
        .done_o  (tx_done)
    );

    ////////////////////////////////////////////////////////////
    // button
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            btn_prev <= 1'b0;
        end else begin
            btn_meta <= btn_i;      // first sync stage
            btn_sync <= btn_meta;
            btn_prev <= btn_sync;
        end
    end

    assign btn_rise = btn_sync & ~btn_prev;

    // remaining sources stay quiet
    always_comb begin
        irq_o              = '0;
        irq_o[SRC_BUTTON]  = btn_rise;
        irq_o[SRC_TX_DONE] = tx_done;
    end

    assign status = {30'h0, btn_sync, tx_busy};

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (addr_i)
                PERIPH_STATUS: rdata_o <= status;
                default:       rdata_o <= 32'h0;    // tx data is write only
            endcase
        end
    end

endmodule

/* rtl/platform_top.sv */
`timescale 1ns/1ps

module platform_top #(
    parameter int IRQ_CNT      = 2,
    parameter int CLKS_PER_BIT = 868,
    parameter int RTC_DIV      = 1
)
(
    input  logic        clk,
    input  logic        rst_i,
    input  logic        en_i,
    input  logic [3:0]  we_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] data_i,
    output logic [31:0] data_o,
    input  logic        btn_i,
    output logic        uart_tx_o,
    output logic        mti_o,
    output logic        mei_o
);

    logic               rtc_en;
    logic               plic_en;
    logic               periph_en;
    logic [31:0]        rtc_rdata;
    logic [31:0]        plic_rdata;
    logic [31:0]        periph_rdata;
    logic [IRQ_CNT:1]   irq_src;

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    bus_decoder u_bus_decoder (
        .clk            (clk),
        .rst_i          (rst_i),
        .en_i           (en_i),
        .addr_region_i  (addr_i[31:28]),
        .rtc_en_o       (rtc_en),
        .plic_en_o      (plic_en),
        .periph_en_o    (periph_en),
        .rtc_rdata_i    (rtc_rdata),
        .plic_rdata_i   (plic_rdata),
        .periph_rdata_i (periph_rdata),
        .data_o         (data_o)
    );

    ////////////////////////////////////////////////////////////
    // targets
    ////////////////////////////////////////////////////////////

    machine_timer #(
        .RTC_DIV (RTC_DIV)
    ) u_machine_timer (
        .clk     (clk),
        .rst_i   (rst_i),
        .en_i    (rtc_en),
        .addr_i  (addr_i[3:0]),
        .we_i    (we_i),
        .data_i  (data_i),
        .rdata_o (rtc_rdata),
        .mti_o   (mti_o)
    );

    irq_controller #(
        .IRQ_CNT (IRQ_CNT)
    ) u_irq_controller (
        .clk     (clk),
        .rst_i   (rst_i),
        .en_i    (plic_en),
        .addr_i  (addr_i[7:0]),
        .we_i    (we_i),
        .data_i  (data_i),
        .rdata_o (plic_rdata),
        .irq_i   (irq_src),
        .mei_o   (mei_o)
    );

    peripherals #(
        .IRQ_CNT      (IRQ_CNT),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_peripherals (
        .clk       (clk),
        .rst_i     (rst_i),
        .en_i      (periph_en),
        .addr_i    (addr_i[7:0]),
        .we_i      (we_i),
        .data_i    (data_i),
        .rdata_o   (periph_rdata),
        .btn_i     (btn_i),
        .uart_tx_o (uart_tx_o),
        .irq_o     (irq_src)
    );

endmodule

/* testbench/tb_platform.sv */
`timescale 1ns/1ps

module tb_platform
    import platform_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int CLKS_PER_BIT = 8;
    localparam int RTC_DIV      = 4;
    localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;    // start, 8 data, stop

    // cycle budgets per test add up to the watchdog limit
    localparam int DECODE_CYCLES = 20;
    localparam int TIMER_CYCLES  = 400;
    localparam int UART_CYCLES   = 3 * FRAME_CYCLES + 100;
    localparam int BUTTON_CYCLES = 100;
    localparam int MASK_CYCLES   = 2 * FRAME_CYCLES + 200;
    localparam int TEST_CYCLES   = DECODE_CYCLES + TIMER_CYCLES + UART_CYCLES
                                 + BUTTON_CYCLES + MASK_CYCLES;
    localparam int WATCHDOG_NS   = (TEST_CYCLES + 800) * CLK_PERIOD;

    logic        clk;
    logic        rst_i;
    logic        en_i;
    logic [3:0]  we_i;
    logic [31:0] addr_i;
    logic [31:0] data_i;
    logic [31:0] data_o;
    logic        btn_i;
    logic        uart_tx_o;
    logic        mti_o;
    logic        mei_o;

    int errors;
    int test_errors_start;
    int tests_passed;
    int tests_failed;

    platform_top #(
        .IRQ_CNT      (2),
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .RTC_DIV      (RTC_DIV)
    ) dut (
        .clk       (clk),
        .rst_i     (rst_i),
        .en_i      (en_i),
        .we_i      (we_i),
        .addr_i    (addr_i),
        .data_i    (data_i),
        .data_o    (data_o),
        .btn_i     (btn_i),
        .uart_tx_o (uart_tx_o),
        .mti_o     (mti_o),
        .mei_o     (mei_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // bus access and checking helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] reg_addr(input region_e region, input logic [7:0] offset);
        logic [31:0] base;
        case (region)
            REGION_RTC:    base = 32'h2000_0000;
            REGION_PLIC:   base = 32'h3000_0000;
            REGION_PERIPH: base = 32'h8000_0000;
            default:       base = 32'h0000_0000;
        endcase
        return base | {24'h0, offset};
    endfunction

    // every task starts and ends 1 ns after a rising edge
    task automatic step_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        en_i   = 1'b1;
        we_i   = 4'hf;
        addr_i = addr;
        data_i = data;
        step_cycles(1);
        en_i = 1'b0;
        we_i = 4'h0;
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        en_i   = 1'b1;
        we_i   = 4'h0;
        addr_i = addr;
        step_cycles(1);
        data = data_o;      // latency of one cycle
        en_i = 1'b0;
    endtask

    task automatic check_eq(input string sig, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic wait_mei(input int max_cycles, output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < max_cycles && !seen; n++) begin
            step_cycles(1);
            seen = mei_o;
        end
    endtask

    task automatic wait_tx_idle(input int max_cycles, output bit idle);
        logic [31:0] st;
        int          n;
        idle = 1'b0;
        for (n = 0; n < max_cycles && !idle; n++) begin
            bus_read(reg_addr(REGION_PERIPH, PERIPH_STATUS), st);
            idle = !st[0];
        end
    endtask

    task automatic report_test(input string name);
        int n;
        n = errors - test_errors_start;
        if (n == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d check(s) failed", name, n);
        end
        test_errors_start = errors;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_decode();
        logic [31:0] rd;
        check_eq("mti_o", 32'(mti_o), 32'h0);
        check_eq("mei_o", 32'(mei_o), 32'h0);
        check_eq("uart_tx_o", 32'(uart_tx_o), 32'h1);
        bus_read(reg_addr(REGION_RAM, 8'h40), rd);
        check_eq("data_o (ram)", rd, 32'h0);
        bus_read(reg_addr(REGION_PERIPH, PERIPH_STATUS), rd);
        check_eq("data_o (status)", rd, 32'h0);     // idle, button low
        bus_read(reg_addr(REGION_PLIC, PLIC_PENDING), rd);
        check_eq("data_o (pending)", rd, 32'h0);
        report_test("reset and decode");
    endtask

    task automatic test_timer();
        logic [31:0] t0;
        logic [31:0] t1;
        logic [31:0] cmp;
        bit          seen;
        int          n;
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_LO), t0);
        cmp = t0 + 32'd30;
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_HI), 32'h0);
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_LO), cmp);
        step_cycles(2);
        check_eq("mti_o", 32'(mti_o), 32'h0);
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_LO), t0);
        step_cycles(RTC_DIV);
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_LO), t1);
        check_true(t1 >= t0, "mtime went backwards between two reads");
        seen = 1'b0;
        for (n = 0; n < TIMER_CYCLES && !seen; n++) begin
            step_cycles(1);
            seen = mti_o;
        end
        check_true(seen, "mti_o never rose although mtime should pass mtimecmp");
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_LO), t1);
        check_true(t1 >= cmp, "mtime read back is below the compare value with mti_o high");
        bus_read(reg_addr(REGION_RTC, RTC_MTIME_HI), t1);
        check_eq("data_o (mtime hi)", t1, 32'h0);
        // compare back to all ones
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_LO), 32'hffff_ffff);
        bus_write(reg_addr(REGION_RTC, RTC_MTIMECMP_HI), 32'hffff_ffff);
        step_cycles(2);
        check_eq("mti_o", 32'(mti_o), 32'h0);
        report_test("machine timer");
    endtask

    task automatic test_uart_frame();
        logic [7:0]  tx_byte;
        logic [9:0]  frame;
        logic [31:0] rd;
        bit          idle;
        int          k;
        int          low_cnt;
        tx_byte = 8'($urandom);
        frame   = {1'b1, tx_byte, 1'b0};    // bit 0 goes out first
        bus_write(reg_addr(REGION_PERIPH, PERIPH_TX_DATA), {24'h0, tx_byte});
        bus_read(reg_addr(REGION_PERIPH, PERIPH_STATUS), rd);
        check_eq("status busy", {31'h0, rd[0]}, 32'h1);
        // one clock into the start bit here
        step_cycles(CLKS_PER_BIT / 2 - 1);
        for (k = 0; k < 10; k++) begin
            check_eq($sformatf("uart_tx_o bit %0d", k), 32'(uart_tx_o), 32'(frame[k]));
            if (k < 9) begin
                step_cycles(CLKS_PER_BIT);
            end
        end
        wait_tx_idle(FRAME_CYCLES, idle);
        check_true(idle, "transmitter stayed busy after the stop bit");

        // second write lands mid frame
        bus_write(reg_addr(REGION_PERIPH, PERIPH_TX_DATA), {24'h0, tx_byte});
        step_cycles(2);
        bus_write(reg_addr(REGION_PERIPH, PERIPH_TX_DATA), {24'h0, ~tx_byte});
        // busy ends with the first frame
        wait_tx_idle(FRAME_CYCLES, idle);
        check_true(idle, "transmitter stayed busy past the end of the first frame");
        low_cnt = 0;
        for (k = 0; k < FRAME_CYCLES; k++) begin
            step_cycles(1);
            if (!uart_tx_o) begin
                low_cnt++;
            end
        end
        check_true(low_cnt == 0, "a write issued while busy started a second frame");
        report_test("uart frame");
    endtask

    task automatic test_button_irq();
        logic [31:0] rd;
        bit          seen;
        bus_write(reg_addr(REGION_PLIC, PLIC_ENABLE), 32'(1 << SRC_BUTTON));
        btn_i = 1'b1;
        wait_mei(20, seen);
        check_true(seen, "mei_o did not rise after the button press");
        bus_read(reg_addr(REGION_PLIC, PLIC_CLAIM), rd);
        check_eq("data_o (claim)", rd, 32'(SRC_BUTTON));
        step_cycles(1);
        check_eq("mei_o", 32'(mei_o), 32'h0);
        bus_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'(SRC_BUTTON));
        btn_i = 1'b0;
        step_cycles(4);
        check_eq("mei_o", 32'(mei_o), 32'h0);
        report_test("button interrupt");
    endtask

    task automatic test_mask_priority();
        logic [31:0] rd;
        bit          seen;
        bus_write(reg_addr(REGION_PLIC, PLIC_ENABLE), 32'(1 << SRC_TX_DONE));
        // frames of the uart test left tx done pending
        bus_read(reg_addr(REGION_PLIC, PLIC_PENDING), rd);
        check_eq("data_o (pending)", rd, 32'(1 << SRC_TX_DONE));
        bus_read(reg_addr(REGION_PLIC, PLIC_CLAIM), rd);
        check_eq("data_o (claim)", rd, 32'(SRC_TX_DONE));
        bus_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'(SRC_TX_DONE));
        step_cycles(2);
        check_eq("mei_o", 32'(mei_o), 32'h0);

        btn_i = 1'b1;   // masked source
        step_cycles(10);
        check_eq("mei_o", 32'(mei_o), 32'h0);
        bus_read(reg_addr(REGION_PLIC, PLIC_PENDING), rd);
        check_eq("data_o (pending)", rd, 32'(1 << SRC_BUTTON));
        btn_i = 1'b0;

        bus_write(reg_addr(REGION_PERIPH, PERIPH_TX_DATA), 32'($urandom) & 32'hff);
        wait_mei(FRAME_CYCLES + 20, seen);
        check_true(seen, "mei_o did not rise when the frame completed");

        bus_read(reg_addr(REGION_PLIC, PLIC_PENDING), rd);
        check_eq("data_o (pending)", rd, 32'((1 << SRC_BUTTON) | (1 << SRC_TX_DONE)));
        bus_write(reg_addr(REGION_PLIC, PLIC_ENABLE),
                  32'((1 << SRC_BUTTON) | (1 << SRC_TX_DONE)));
        bus_read(reg_addr(REGION_PLIC, PLIC_CLAIM), rd);
        check_eq("data_o (claim)", rd, 32'(SRC_BUTTON));
        bus_read(reg_addr(REGION_PLIC, PLIC_PENDING), rd);
        check_eq("data_o (pending)", rd, 32'(1 << SRC_TX_DONE));
        bus_read(reg_addr(REGION_PLIC, PLIC_CLAIM), rd);
        check_eq("data_o (claim)", rd, 32'(SRC_TX_DONE));
        bus_read(reg_addr(REGION_PLIC, PLIC_PENDING), rd);
        check_eq("data_o (pending)", rd, 32'h0);
        bus_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'(SRC_BUTTON));
        bus_write(reg_addr(REGION_PLIC, PLIC_CLAIM), 32'(SRC_TX_DONE));
        step_cycles(2);
        check_eq("mei_o", 32'(mei_o), 32'h0);
        report_test("masking and priority");
    endtask

    ////////////////////////////////////////////////////////////
    // run
    ////////////////////////////////////////////////////////////

    initial begin
        clk               = 1'b0;
        rst_i             = 1'b1;
        en_i              = 1'b0;
        we_i              = 4'h0;
        addr_i            = 32'h0;
        data_i            = 32'h0;
        btn_i             = 1'b0;
        errors            = 0;
        test_errors_start = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        void'($urandom(32'h30df));

        repeat (3) @(posedge clk);
        #1;
        rst_i = 1'b0;

        test_reset_decode();
        test_timer();
        test_uart_frame();
        test_button_irq();
        test_mask_priority();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* build.f */
rtl/platform_pkg.sv
rtl/bus_decoder.sv
rtl/machine_timer.sv
rtl/irq_controller.sv
rtl/uart_tx.sv
rtl/peripherals.sv
rtl/platform_top.sv
testbench/tb_platform.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the platform testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_platform \
    -f build.f \
    -o tb_platform

./obj_dir/tb_platform | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation clean"
